//--- include/pr_defines.svh
// rank scheduler sizes and APB register map
// shared by the package and the RTL blocks

`ifndef PR_DEFINES_SVH
`define PR_DEFINES_SVH

// matrix and vector geometry
`define PR_N          8
`define PR_ELEM_W     8
`define PR_WORD_W     32
`define PR_LANES      4
`define PR_CHUNKS     2

// bus widths
`define PR_ADDR_W     32
`define PR_APB_ADDR_W 8

// APB register offsets
`define PR_REG_CTRL   8'h00
`define PR_REG_BASE_G 8'h04
`define PR_REG_BASE_R 8'h08
`define PR_REG_STATUS 8'h0C
`define PR_REG_RANK0  8'h10

`endif

//--- rtl/pr_pkg.sv
// rank scheduler package
// element and bus types, FSM states and grouped strobes

`default_nettype none

`include "pr_defines.svh"

package pr_pkg;

  // ----------------------------------------
  // plain vector types
  // ----------------------------------------
  typedef logic [`PR_ELEM_W-1:0]          elem_t;
  typedef logic [`PR_WORD_W-1:0]          word_t;
  typedef logic [`PR_ADDR_W-1:0]          addr_t;
  typedef logic [$clog2(`PR_N)-1:0]       row_idx_t;
  typedef logic [$clog2(`PR_CHUNKS)-1:0]  chunk_idx_t;

  // scheduler states
  typedef enum logic [3:0] {
    IDLE,
    REQ_R,
    WAIT_R,
    REQ_G,
    WAIT_G,
    ACC
  } pr_state_t;

  // ----------------------------------------
  // grouped signals
  // ----------------------------------------
  // strobes from the FSM to counter and datapath
  typedef struct packed {
    logic load_r;
    logic load_g;
    logic acc_en;
    logic row_step;
    logic chunk_step;
  } pr_ctl_t;

  // APB inputs seen by the slave
  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`PR_APB_ADDR_W-1:0] paddr;
    word_t                     pwdata;
  } apb_req_t;

endpackage

`default_nettype wire

//--- rtl/pr_ctrl_fsm.sv
// rank scheduler control FSM
// sequences R and G reads and triggers one accumulate per row

`default_nettype none

module pr_ctrl_fsm (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  logic            row_last,
  input  logic            chunk_last,
  input  logic            mem_req_rdy,
  input  logic            mem_resp_val,
  output logic            mem_req_val,
  output logic            mem_resp_rdy,
  output pr_pkg::pr_ctl_t ctl,
  output logic            busy,
  output logic            done
);

  import pr_pkg::*;

  pr_state_t state;
  pr_state_t state_next;

  logic req_go;
  logic resp_go;
  logic run_end;

  // ----------------------------------------
  // handshakes
  // ----------------------------------------
  // one read in flight, so request and response states never overlap
  assign mem_req_val  = (state == REQ_R) || (state == REQ_G);
  assign mem_resp_rdy = (state == WAIT_R) || (state == WAIT_G);
  assign req_go       = mem_req_val && mem_req_rdy;
  assign resp_go      = mem_resp_val && mem_resp_rdy;

  // last row of last chunk
  assign run_end = (state == ACC) && row_last && chunk_last;

  // ----------------------------------------
  // state register and transitions
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:    if (start) state_next = REQ_R;
      REQ_R:   if (req_go) state_next = WAIT_R;
      WAIT_R:  if (resp_go) state_next = REQ_G;
      REQ_G:   if (req_go) state_next = WAIT_G;
      WAIT_G:  if (resp_go) state_next = ACC;
      // single cycle accumulate then next row or next chunk
      ACC: begin
        if (!row_last) begin
          state_next = REQ_G;
        end else if (!chunk_last) begin
          state_next = REQ_R;
        end else begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  // ----------------------------------------
  // strobes
  // ----------------------------------------
  always_comb begin
    ctl            = '0;
    ctl.load_r     = (state == WAIT_R) && resp_go;
    ctl.load_g     = (state == WAIT_G) && resp_go;
    ctl.acc_en     = (state == ACC);
    ctl.row_step   = (state == ACC);
    ctl.chunk_step = (state == ACC) && row_last;
  end

  assign busy = (state != IDLE);

  // done holds until the next accepted start
  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else if (start && (state == IDLE)) begin
      done <= 1'b0;
    end else if (run_end) begin
      done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/pr_iter_counter.sv
// row and chunk iteration counters
// also forms the byte address of the next R or G word

`default_nettype none

`include "pr_defines.svh"

module pr_iter_counter (
  input  logic               clk,
  input  logic               reset,
  input  pr_pkg::pr_ctl_t    ctl,
  input  pr_pkg::addr_t      base_g,
  input  pr_pkg::addr_t      base_r,
  output pr_pkg::row_idx_t   row,
  output pr_pkg::chunk_idx_t chunk,
  output logic               row_last,
  output logic               chunk_last,
  output pr_pkg::addr_t      mem_req_addr
);

  import pr_pkg::*;

  // high while the next read is an R chunk
  logic  r_phase;
  addr_t r_addr;
  addr_t g_addr;

  // ----------------------------------------
  // counters
  // ----------------------------------------
  // both wrap to zero so a new run starts clean
  always_ff @(posedge clk) begin
    if (reset) begin
      row     <= '0;
      chunk   <= '0;
      r_phase <= 1'b1;
    end else begin
      if (ctl.row_step) row <= row + 1'b1;
      if (ctl.chunk_step) chunk <= chunk + 1'b1;
      if (ctl.chunk_step) begin
        r_phase <= 1'b1;
      end else if (ctl.load_r) begin
        r_phase <= 1'b0;
      end
    end
  end

  assign row_last   = (row == row_idx_t'(`PR_N - 1));
  assign chunk_last = (chunk == chunk_idx_t'(`PR_CHUNKS - 1));

  // ----------------------------------------
  // address generation
  // ----------------------------------------
  // chunk offset is the byte count of one word
  assign r_addr = base_r + addr_t'(`PR_LANES) * addr_t'(chunk);
  assign g_addr = base_g + addr_t'(`PR_N) * addr_t'(row)
                + addr_t'(`PR_LANES) * addr_t'(chunk);

  assign mem_req_addr = r_phase ? r_addr : g_addr;

endmodule

`default_nettype wire

//--- rtl/pr_rank_datapath.sv
// rank datapath
// holds R and G lanes and accumulates the 4-lane dot product per row

`default_nettype none

`include "pr_defines.svh"

module pr_rank_datapath (
  input  logic                          clk,
  input  logic                          reset,
  input  pr_pkg::pr_ctl_t               ctl,
  input  pr_pkg::row_idx_t              row,
  input  pr_pkg::chunk_idx_t            chunk,
  input  pr_pkg::word_t                 mem_resp_data,
  output pr_pkg::elem_t [`PR_N-1:0]     rank
);

  import pr_pkg::*;

  // word split into byte lanes, lane 0 in the low byte
  elem_t [`PR_LANES-1:0] resp_lane;

  // current R chunk and current G row slice
  elem_t [`PR_LANES-1:0] r_lane;
  elem_t [`PR_LANES-1:0] g_lane;

  elem_t dot;
  elem_t rank_next;

  assign resp_lane = mem_resp_data;

  // ----------------------------------------
  // lane registers
  // ----------------------------------------
  // payload only, written on the response handshake
  always_ff @(posedge clk) begin
    if (ctl.load_r) r_lane <= resp_lane;
    if (ctl.load_g) g_lane <= resp_lane;
  end

  // ----------------------------------------
  // dot product
  // ----------------------------------------
  // all sums wrap modulo 256
  always_comb begin
    dot = '0;
    for (int i = 0; i < `PR_LANES; i++) begin
      dot = dot + elem_t'(r_lane[i] * g_lane[i]);
    end
  end

  // first chunk overwrites the old rank
  assign rank_next = (chunk != '0) ? (rank[row] + dot) : dot;

  // ----------------------------------------
  // rank accumulators
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      rank <= '0;
    end else if (ctl.acc_en) begin
      rank[row] <= rank_next;
    end
  end

endmodule

`default_nettype wire

//--- rtl/pr_apb_regs.sv
// APB register file for the rank scheduler
// base addresses, start control, status and rank readout

`default_nettype none

`include "pr_defines.svh"

module pr_apb_regs (
  input  logic                      clk,
  input  logic                      reset,
  input  pr_pkg::apb_req_t          apb,
  input  logic                      busy,
  input  logic                      done,
  input  pr_pkg::elem_t [`PR_N-1:0] rank,
  output pr_pkg::word_t             prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      start,
  output pr_pkg::addr_t             base_g,
  output pr_pkg::addr_t             base_r
);

  import pr_pkg::*;

  logic access;
  logic wr;
  logic aligned;
  logic sel_ctrl, sel_base_g, sel_base_r, sel_status, sel_rank;
  logic [`PR_APB_ADDR_W-1:0] rank_off;
  row_idx_t rank_idx;

  // ----------------------------------------
  // decode
  // ----------------------------------------
  // access phase only, no wait states
  assign access  = apb.psel && apb.penable;
  assign wr      = access && apb.pwrite;
  assign aligned = (apb.paddr[1:0] == 2'b00);

  assign rank_off = apb.paddr - `PR_REG_RANK0;
  assign rank_idx = row_idx_t'(rank_off >> 2);

  assign sel_ctrl   = (apb.paddr == `PR_REG_CTRL);
  assign sel_base_g = (apb.paddr == `PR_REG_BASE_G);
  assign sel_base_r = (apb.paddr == `PR_REG_BASE_R);
  assign sel_status = (apb.paddr == `PR_REG_STATUS);
  assign sel_rank   = aligned && (apb.paddr >= `PR_REG_RANK0) && ((rank_off >> 2) < `PR_N);

  // unmapped offsets and writes to read-only registers
  assign pslverr = access && (!(sel_ctrl || sel_base_g || sel_base_r || sel_status || sel_rank)
                              || (apb.pwrite && (sel_status || sel_rank)));
  assign pready  = 1'b1;

  // FSM samples this on the access edge
  assign start = wr && sel_ctrl && apb.pwdata[0] && !busy;

  // ----------------------------------------
  // base registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      base_g <= '0;
      base_r <= '0;
    end else if (wr && !busy) begin
      if (sel_base_g) base_g <= apb.pwdata;
      if (sel_base_r) base_r <= apb.pwdata;
    end
  end

  // readout, CTRL reads zero
  always_comb begin
    prdata = '0;
    if (sel_base_g) prdata = word_t'(base_g);
    if (sel_base_r) prdata = word_t'(base_r);
    if (sel_status) prdata = word_t'({done, busy});
    if (sel_rank) prdata = word_t'(rank[rank_idx]);
  end

endmodule

`default_nettype wire

//--- rtl/pr_scheduler_top.sv
// rank scheduler top level
// joins APB registers, FSM, iteration counter and datapath

`default_nettype none

`include "pr_defines.svh"

module pr_scheduler_top (
  input  logic             clk,
  input  logic             reset,
  input  pr_pkg::apb_req_t apb,
  output pr_pkg::word_t    prdata,
  output logic             pready,
  output logic             pslverr,
  output logic             mem_req_val,
  output pr_pkg::addr_t    mem_req_addr,
  input  logic             mem_req_rdy,
  input  logic             mem_resp_val,
  input  pr_pkg::word_t    mem_resp_data,
  output logic             mem_resp_rdy
);

  // ----------------------------------------
  // internal nets
  // ----------------------------------------
  logic                      start, busy, done;
  logic                      row_last, chunk_last;
  pr_pkg::pr_ctl_t           ctl;
  pr_pkg::addr_t             base_g, base_r;
  pr_pkg::row_idx_t          row;
  pr_pkg::chunk_idx_t        chunk;
  pr_pkg::elem_t [`PR_N-1:0] rank;

  // configuration side
  pr_apb_regs pr_apb_regs_i (
    .clk, .reset, .apb, .busy, .done, .rank,
    .prdata, .pready, .pslverr, .start, .base_g, .base_r
  );

  // sequencing
  pr_ctrl_fsm pr_ctrl_fsm_i (
    .clk, .reset, .start, .row_last, .chunk_last,
    .mem_req_rdy, .mem_resp_val, .mem_req_val, .mem_resp_rdy,
    .ctl, .busy, .done
  );

  // loop indices and read address
  pr_iter_counter pr_iter_counter_i (
    .clk, .reset, .ctl, .base_g, .base_r,
    .row, .chunk, .row_last, .chunk_last, .mem_req_addr
  );

  // lanes and rank storage
  pr_rank_datapath pr_rank_datapath_i (
    .clk, .reset, .ctl, .row, .chunk, .mem_resp_data, .rank
  );

endmodule

`default_nettype wire

//--- tb/pr_mem_model.sv
// behavioral byte memory for the rank scheduler
// one read at a time, random request stall and response latency

`default_nettype none

module pr_mem_model (
  input  logic          clk,
  input  logic          reset,
  input  logic          stall_en,
  input  logic          mem_req_val,
  input  pr_pkg::addr_t mem_req_addr,
  output logic          mem_req_rdy,
  output logic          mem_resp_val,
  output pr_pkg::word_t mem_resp_data,
  input  logic          mem_resp_rdy
);

  import pr_pkg::*;

  // byte storage, filled by the testbench
  logic [7:0] mem [256];

  logic  pending;
  addr_t addr_q;
  int    lat;
  int    req_count;

  initial begin
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_data = '0;
    pending       = 1'b0;
    lat           = 0;
    req_count     = 0;
  end

  // four byte lanes, lane 0 low, address wraps in 256 bytes
  function automatic word_t read_word(addr_t a);
    logic [7:0] b;
    b = a[7:0];
    return {mem[b + 8'd3], mem[b + 8'd2], mem[b + 8'd1], mem[b]};
  endfunction

  // ----------------------------------------
  // handshakes seen on the rising edge
  // ----------------------------------------
  always @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (mem_req_val && mem_req_rdy) begin
      pending   <= 1'b1;
      addr_q    <= mem_req_addr;
      req_count <= req_count + 1;
    end else if (mem_resp_val && mem_resp_rdy) begin
      pending <= 1'b0;
    end
  end

  // outputs move on the falling edge
  always @(negedge clk) begin
    if (reset) begin
      mem_req_rdy  <= 1'b0;
      mem_resp_val <= 1'b0;
      lat          <= 0;
    end else if (pending) begin
      mem_req_rdy <= 1'b0;
      // count down latency, then hold data until taken
      if (!mem_resp_val) begin
        if (lat == 0) begin
          mem_resp_val  <= 1'b1;
          mem_resp_data <= read_word(addr_q);
        end else begin
          lat <= lat - 1;
        end
      end
    end else begin
      mem_resp_val <= 1'b0;
      mem_req_rdy  <= stall_en ? ($urandom % 4 != 0) : 1'b1;
      lat          <= stall_en ? int'($urandom % 6) : 0;
    end
  end

endmodule

`default_nettype wire

//--- tb/pr_scheduler_properties.sv
// handshake checks on the rank scheduler memory and APB ports
// bound into the top level

`default_nettype none

module pr_scheduler_properties (
  input logic          clk,
  input logic          reset,
  input logic          mem_req_val,
  input pr_pkg::addr_t mem_req_addr,
  input logic          mem_req_rdy,
  input logic          mem_resp_val,
  input logic          mem_resp_rdy,
  input logic          pready
);

  // request accepted, response not yet taken
  logic outstanding;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 1'b0;
    end else if (mem_req_val && mem_req_rdy) begin
      outstanding <= 1'b1;
    end else if (mem_resp_val && mem_resp_rdy) begin
      outstanding <= 1'b0;
    end
  end

  // ----------------------------------------
  // request held steady under back-pressure
  req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req_addr))
    else $error("memory request dropped or changed before acceptance");

  // single read in flight
  one_outstanding: assert property (@(posedge clk) disable iff (reset)
    outstanding |-> !mem_req_val)
    else $error("new memory request while a response is pending");

  // no APB wait states
  apb_no_wait: assert property (@(posedge clk) disable iff (reset) pready)
    else $error("pready went low");

endmodule

bind pr_scheduler_top pr_scheduler_properties pr_scheduler_properties_i (
  .clk, .reset, .mem_req_val, .mem_req_addr, .mem_req_rdy,
  .mem_resp_val, .mem_resp_rdy, .pready
);

`default_nettype wire

//--- tb/pr_scheduler_tb.sv
// testbench for the rank scheduler
// APB tasks, reference ranks and directed tests

`default_nettype none

`include "pr_defines.svh"

module pr_scheduler_tb;

  import pr_pkg::*;

  logic     clk;
  logic     reset;
  logic     stall_en;
  apb_req_t apb;
  word_t    prdata;
  logic     pready;
  logic     pslverr;
  logic     mem_req_val;
  addr_t    mem_req_addr;
  logic     mem_req_rdy;
  logic     mem_resp_val;
  word_t    mem_resp_data;
  logic     mem_resp_rdy;

  // last APB readout
  word_t rd_data;
  logic  slv_err;
  int    err_count;
  int    check_count;

  pr_scheduler_top pr_scheduler_top_i (
    .clk, .reset, .apb, .prdata, .pready, .pslverr, .mem_req_val, .mem_req_addr,
    .mem_req_rdy, .mem_resp_val, .mem_resp_data, .mem_resp_rdy
  );

  pr_mem_model mem_model_i (
    .clk, .reset, .stall_en, .mem_req_val, .mem_req_addr, .mem_req_rdy,
    .mem_resp_val, .mem_resp_data, .mem_resp_rdy
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // checks and APB access
  // ----------------------------------------
  task automatic check_word(string name, word_t got, word_t exp);
    check_count++;
    assert (got == exp) else begin
      $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_true(logic cond, string what);
    check_count++;
    assert (cond) else begin
      $display("%s", what);
      err_count++;
    end
  endtask

  // setup then access phase, sampled mid low phase before the access edge
  task automatic apb_access(logic write, logic [`PR_APB_ADDR_W-1:0] addr, word_t wdata);
    int waits;
    waits = 0;
    @(negedge clk);
    apb.psel    = 1'b1;
    apb.penable = 1'b0;
    apb.pwrite  = write;
    apb.paddr   = addr;
    apb.pwdata  = wdata;
    @(negedge clk);
    apb.penable = 1'b1;
    #1;
    while (!pready && waits < 16) begin
      @(negedge clk);
      #1;
      waits++;
    end
    check_true(pready, "APB transfer never saw pready");
    rd_data = prdata;
    slv_err = pslverr;
    @(negedge clk);
    apb.psel    = 1'b0;
    apb.penable = 1'b0;
    apb.pwrite  = 1'b0;
  endtask

  task automatic apb_write(logic [`PR_APB_ADDR_W-1:0] addr, word_t data);
    apb_access(1'b1, addr, data);
  endtask

  task automatic apb_read(logic [`PR_APB_ADDR_W-1:0] addr);
    apb_access(1'b0, addr, '0);
  endtask

  // ----------------------------------------
  // memory contents and reference ranks
  // ----------------------------------------
  task automatic fill_random(addr_t base, int count);
    for (int i = 0; i < count; i++) begin
      mem_model_i.mem[8'(base + addr_t'(i))] = 8'($urandom);
    end
  endtask

  // rank[j] = sum over k of G[j][k] * R[k], modulo 256
  function automatic elem_t ref_rank(addr_t bg, addr_t br, int j);
    elem_t acc;
    elem_t g;
    elem_t r;
    acc = '0;
    for (int k = 0; k < `PR_N; k++) begin
      g   = mem_model_i.mem[8'(bg + addr_t'(`PR_N * j + k))];
      r   = mem_model_i.mem[8'(br + addr_t'(k))];
      acc = acc + elem_t'(g * r);
    end
    return acc;
  endfunction

  task automatic check_ranks(addr_t bg, addr_t br);
    for (int j = 0; j < `PR_N; j++) begin
      apb_read(`PR_REG_RANK0 + 8'(4 * j));
      check_word($sformatf("rank[%0d]", j), rd_data, word_t'(ref_rank(bg, br, j)));
    end
  endtask

  // poll STATUS until done, bounded
  task automatic wait_done();
    int polls;
    polls = 0;
    apb_read(`PR_REG_STATUS);
    while (!rd_data[1] && polls < 2000) begin
      apb_read(`PR_REG_STATUS);
      polls++;
    end
    check_true(rd_data[1], "run did not finish within the poll limit");
    check_word("STATUS", rd_data, 32'h2);
  endtask

  task automatic run_check(addr_t bg, addr_t br);
    apb_write(`PR_REG_BASE_G, bg);
    apb_write(`PR_REG_BASE_R, br);
    apb_write(`PR_REG_CTRL, 32'h1);
    wait_done();
    check_ranks(bg, br);
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_reset_state();
    apb_read(`PR_REG_STATUS);
    check_word("STATUS", rd_data, 32'h0);
    for (int j = 0; j < `PR_N; j++) begin
      apb_read(`PR_REG_RANK0 + 8'(4 * j));
      check_word($sformatf("rank[%0d]", j), rd_data, 32'h0);
    end
    apb_write(`PR_REG_BASE_G, 32'h1234_5678);
    apb_read(`PR_REG_BASE_G);
    check_word("BASE_G", rd_data, 32'h1234_5678);
    apb_write(`PR_REG_BASE_R, 32'h9abc_def0);
    apb_read(`PR_REG_BASE_R);
    check_word("BASE_R", rd_data, 32'h9abc_def0);
  endtask

  task automatic test_no_stall();
    stall_en = 1'b0;
    fill_random(32'h00, 64);
    fill_random(32'h80, 8);
    run_check(32'h00, 32'h80);
  endtask

  // restart and base writes while busy must leave the run alone
  task automatic test_busy_restart();
    int reqs_before;
    stall_en = 1'b0;
    fill_random(32'h00, 64);
    fill_random(32'h80, 8);
    apb_write(`PR_REG_BASE_G, 32'h00);
    apb_write(`PR_REG_BASE_R, 32'h80);
    reqs_before = mem_model_i.req_count;
    apb_write(`PR_REG_CTRL, 32'h1);
    apb_read(`PR_REG_STATUS);
    check_word("STATUS", rd_data, 32'h1);
    apb_write(`PR_REG_CTRL, 32'h1);
    apb_write(`PR_REG_BASE_G, 32'h40);
    wait_done();
    // one R read and eight G reads per chunk
    check_word("mem requests", word_t'(mem_model_i.req_count - reqs_before),
               word_t'(`PR_CHUNKS * (`PR_N + 1)));
    apb_read(`PR_REG_BASE_G);
    check_word("BASE_G", rd_data, 32'h0);
    check_ranks(32'h00, 32'h80);
  endtask

  task automatic test_random_stall();
    stall_en = 1'b1;
    fill_random(32'h40, 64);
    fill_random(32'hc0, 8);
    run_check(32'h40, 32'hc0);
  endtask

  task automatic test_slave_error();
    apb_read(8'h30);
    check_true(slv_err, "read of unmapped offset 0x30 gave no pslverr");
    apb_write(`PR_REG_STATUS, 32'h3);
    check_true(slv_err, "write to STATUS gave no pslverr");
    apb_read(`PR_REG_STATUS);
    check_true(!slv_err, "read of STATUS raised pslverr");
    // new data so the ranks left from the last run cannot match
    fill_random(32'h00, 64);
    fill_random(32'h80, 8);
    run_check(32'h00, 32'h80);
  endtask

  // second data set must overwrite, not add to, the first ranks
  task automatic test_rebase();
    stall_en = 1'b1;
    fill_random(32'h00, 64);
    fill_random(32'h80, 8);
    run_check(32'h00, 32'h80);
    fill_random(32'h40, 64);
    fill_random(32'hc0, 8);
    run_check(32'h40, 32'hc0);
  endtask

  initial begin
    void'($urandom(32'h60ba2605));
    err_count   = 0;
    check_count = 0;
    rd_data     = '0;
    slv_err     = 1'b0;
    stall_en    = 1'b0;
    apb         = '0;
    reset       = 1'b1;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_no_stall();
    test_busy_restart();
    test_random_stall();
    test_slave_error();
    test_rebase();
    $display("checks %0d errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
rtl/pr_pkg.sv
rtl/pr_ctrl_fsm.sv
rtl/pr_iter_counter.sv
rtl/pr_rank_datapath.sv
rtl/pr_apb_regs.sv
rtl/pr_scheduler_top.sv
tb/pr_mem_model.sv
tb/pr_scheduler_properties.sv
tb/pr_scheduler_tb.sv

//--- run.sh
#!/bin/sh
# build the rank scheduler testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module pr_scheduler_tb -o pr_scheduler_sim || exit 1
out=$(./obj_dir/pr_scheduler_sim)
echo "$out"
echo "$out" | grep -q "STATUS: PASS" && exit 0 || exit 1
